//--- source/mem_access_pkg.sv
package mem_access_pkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;
    localparam int ID_W = 4;

    typedef logic [XLEN-1:0] xlen_t;   // data and address word
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [ID_W-1:0] req_id_t; // read port tag

    localparam req_id_t ID_FETCH = 4'd1;
    localparam req_id_t ID_LOAD  = 4'd2;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        L_IDLE = 2'd0,
        L_REQ  = 2'd1, // waiting for grant
        L_WAIT = 2'd2, // waiting for tagged return
        L_DONE = 2'd3
    } load_state_e;

    typedef enum logic [1:0] {
        F_IDLE = 2'd0,
        F_REQ  = 2'd1,
        F_WAIT = 2'd2,
        F_DONE = 2'd3
    } fetch_state_e;

endpackage

//--- source/load_unit.sv
`timescale 1ns/1ps

module load_unit import mem_access_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ld_start,
    input  xlen_t     rs1_val,
    input  xlen_t     imm_val,
    input  mem_size_e ld_size,
    input  logic      ld_signed,
    input  xlen_t     ex_result,
    output logic      ld_req,
    output xlen_t     ld_addr,
    input  logic      ld_ar_hs,
    input  logic      r_done,
    input  req_id_t   r_id,
    input  xlen_t     r_data,
    output logic      ld_done,
    output xlen_t     ld_result,
    output xlen_t     wb_result
);

    load_state_e state;
    load_state_e state_nxt;
    xlen_t       rs1_q;
    xlen_t       imm_q;
    mem_size_e   size_q;
    logic        signed_q;
    logic        take_ret;
    xlen_t       lane;
    xlen_t       ext_data;

    assign take_ret = r_done && (r_id == ID_LOAD); // ignore fetch returns

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= L_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            L_IDLE: begin
                if (ld_start) begin
                    state_nxt = L_REQ;
                end
            end
            L_REQ: begin
                if (ld_ar_hs) begin
                    state_nxt = L_WAIT;
                end
            end
            L_WAIT: begin
                if (take_ret) begin
                    state_nxt = L_DONE;
                end
            end
            L_DONE:  state_nxt = L_IDLE;
            default: state_nxt = L_IDLE;
        endcase
    end

    // operands only taken when idle, so a second start is dropped
    always_ff @(posedge clk) begin
        if (state == L_IDLE && ld_start) begin
            rs1_q    <= rs1_val;
            imm_q    <= imm_val;
            size_q   <= ld_size;
            signed_q <= ld_signed;
        end
    end

    assign ld_addr = rs1_q + imm_q;

    // move the addressed byte lane down to bit 0
    assign lane = r_data >> {ld_addr[2:0], 3'b000};

    always_comb begin
        case (size_q)
            SIZE_B: begin
                ext_data = {{56{signed_q & lane[7]}}, lane[7:0]};
            end
            SIZE_H: begin
                ext_data = {{48{signed_q & lane[15]}}, lane[15:0]};
            end
            SIZE_W: begin
                ext_data = {{32{signed_q & lane[31]}}, lane[31:0]};
            end
            default: begin
                ext_data = lane; // full double
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == L_WAIT && take_ret) begin
            ld_result <= ext_data;
        end
    end

    assign ld_req  = (state == L_REQ);
    assign ld_done = (state == L_DONE);

    // pass the execute result through when no load is in progress
    assign wb_result = (state == L_IDLE) ? ex_result : ld_result;

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import mem_access_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    if_start,
    input  xlen_t   pc,
    output logic    if_req,
    output xlen_t   if_addr,
    input  logic    if_ar_hs,
    input  logic    r_done,
    input  req_id_t r_id,
    input  xlen_t   r_data,
    output logic    if_valid,
    output inst_t   inst
);

    fetch_state_e state;
    fetch_state_e state_nxt;
    xlen_t        pc_q;
    logic         take_ret;

    assign take_ret = r_done && (r_id == ID_FETCH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            F_IDLE: begin
                if (if_start) begin
                    state_nxt = F_REQ;
                end
            end
            F_REQ: begin
                if (if_ar_hs) begin
                    state_nxt = F_WAIT;
                end
            end
            F_WAIT: begin
                if (take_ret) begin
                    state_nxt = F_DONE;
                end
            end
            F_DONE:  state_nxt = F_IDLE;
            default: state_nxt = F_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && if_start) begin
            pc_q <= pc;
        end
        if (state == F_WAIT && take_ret) begin
            inst <= pc_q[2] ? r_data[63:32] : r_data[31:0]; // upper half for pc bit 2
        end
    end

    assign if_addr  = pc_q;
    assign if_req   = (state == F_REQ);
    assign if_valid = (state == F_DONE);

endmodule

//--- source/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter import mem_access_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ld_req,
    input  xlen_t   ld_addr,
    input  logic    if_req,
    input  xlen_t   if_addr,
    output logic    ld_ar_hs,
    output logic    if_ar_hs,
    output logic    mem_ar_valid,
    output xlen_t   mem_ar_addr,
    output req_id_t mem_ar_id,
    input  logic    mem_r_done
);

    logic busy;    // one read in flight
    logic last_ld; // load won the previous grant
    logic pick_ld;

    // on a tie the unit not served last wins
    assign pick_ld = ld_req && (!if_req || !last_ld);

    assign ld_ar_hs = !busy && pick_ld;
    assign if_ar_hs = !busy && if_req && !pick_ld;

    assign mem_ar_valid = ld_ar_hs || if_ar_hs;
    assign mem_ar_addr  = ld_ar_hs ? ld_addr : if_addr;

    always_comb begin
        if (ld_ar_hs) begin
            mem_ar_id = ID_LOAD;
        end else if (if_ar_hs) begin
            mem_ar_id = ID_FETCH;
        end else begin
            mem_ar_id = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (mem_ar_valid) begin
            busy <= 1'b1;
        end else if (mem_r_done) begin
            busy <= 1'b0; // port free from next cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ld <= 1'b0; // fetch counts as served last
        end else if (mem_ar_valid) begin
            last_ld <= ld_ar_hs;
        end
    end

endmodule

//--- source/data_memory.sv
`timescale 1ns/1ps

module data_memory import mem_access_pkg::*; #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_en,
    input  xlen_t   wr_addr,
    input  xlen_t   wr_data,
    input  logic    ar_valid,
    input  xlen_t   ar_addr,
    input  req_id_t ar_id,
    output logic    r_done,
    output xlen_t   r_data,
    output req_id_t r_id
);

    localparam int AW = $clog2(MEM_DEPTH);

    xlen_t   mem [MEM_DEPTH];
    logic    [AW-1:0] wr_idx;
    logic    [AW-1:0] rd_idx;

    // return pipeline, stage MEM_LATENCY-1 drives the outputs
    logic    vld_pipe  [MEM_LATENCY];
    xlen_t   data_pipe [MEM_LATENCY];
    req_id_t id_pipe   [MEM_LATENCY];

    assign wr_idx = wr_addr[AW+2:3]; // word index, byte offset dropped
    assign rd_idx = ar_addr[AW+2:3];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= 1'b0;
            end
        end else begin
            vld_pipe[0] <= ar_valid;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_idx]; // sampled at the handshake
        id_pipe[0]   <= ar_id;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
            id_pipe[i]   <= id_pipe[i-1];
        end
    end

    assign r_done = vld_pipe[MEM_LATENCY-1];
    assign r_data = data_pipe[MEM_LATENCY-1];
    assign r_id   = id_pipe[MEM_LATENCY-1];

endmodule

//--- source/mem_access_top.sv
`timescale 1ns/1ps

module mem_access_top import mem_access_pkg::*; #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ld_start,
    input  xlen_t     rs1_val,
    input  xlen_t     imm_val,
    input  mem_size_e ld_size,
    input  logic      ld_signed,
    input  xlen_t     ex_result,
    output logic      ld_done,
    output xlen_t     ld_result,
    output xlen_t     wb_result,
    input  logic      if_start,
    input  xlen_t     pc,
    output logic      if_valid,
    output inst_t     inst,
    input  logic      wr_en,
    input  xlen_t     wr_addr,
    input  xlen_t     wr_data
);

    logic    ld_req;
    xlen_t   ld_addr;
    logic    ld_ar_hs;
    logic    if_req;
    xlen_t   if_addr;
    logic    if_ar_hs;
    logic    mem_ar_valid;
    xlen_t   mem_ar_addr;
    req_id_t mem_ar_id;
    logic    r_done;   // shared return, both units filter by tag
    xlen_t   r_data;
    req_id_t r_id;

    load_unit u_load (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_start  (ld_start),
        .rs1_val   (rs1_val),
        .imm_val   (imm_val),
        .ld_size   (ld_size),
        .ld_signed (ld_signed),
        .ex_result (ex_result),
        .ld_req    (ld_req),
        .ld_addr   (ld_addr),
        .ld_ar_hs  (ld_ar_hs),
        .r_done    (r_done),
        .r_id      (r_id),
        .r_data    (r_data),
        .ld_done   (ld_done),
        .ld_result (ld_result),
        .wb_result (wb_result)
    );

    fetch_unit u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_start (if_start),
        .pc       (pc),
        .if_req   (if_req),
        .if_addr  (if_addr),
        .if_ar_hs (if_ar_hs),
        .r_done   (r_done),
        .r_id     (r_id),
        .r_data   (r_data),
        .if_valid (if_valid),
        .inst     (inst)
    );

    read_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_req       (ld_req),
        .ld_addr      (ld_addr),
        .if_req       (if_req),
        .if_addr      (if_addr),
        .ld_ar_hs     (ld_ar_hs),
        .if_ar_hs     (if_ar_hs),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_addr  (mem_ar_addr),
        .mem_ar_id    (mem_ar_id),
        .mem_r_done   (r_done)
    );

    data_memory #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ar_valid (mem_ar_valid),
        .ar_addr  (mem_ar_addr),
        .ar_id    (mem_ar_id),
        .r_done   (r_done),
        .r_data   (r_data),
        .r_id     (r_id)
    );

endmodule

//--- tests/mem_access_checker.sv
`timescale 1ns/1ps

// bound twice, unused inputs are tied low at the bind
module mem_access_checker (
    input logic clk,
    input logic rst_n,
    input logic req_a,
    input logic req_b,
    input logic hs_a,
    input logic hs_b,
    input logic rd_done,
    input logic done
);

    logic in_flight; // granted read not yet returned

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (hs_a || hs_b) begin
            in_flight <= 1'b1;
        end else if (rd_done) begin
            in_flight <= 1'b0;
        end
    end

    a_single_grant: assert property (@(posedge clk) disable iff (!rst_n) !(hs_a && hs_b))
        else $error("both grants high in one cycle");

    a_grant_a_req: assert property (@(posedge clk) disable iff (!rst_n) hs_a |-> req_a)
        else $error("grant a without its request");

    a_grant_b_req: assert property (@(posedge clk) disable iff (!rst_n) hs_b |-> req_b)
        else $error("grant b without its request");

    a_no_grant_busy: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight |-> !(hs_a || hs_b))
        else $error("grant while a read is in flight");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done strobe longer than one cycle");

endmodule

bind read_arbiter mem_access_checker u_arb_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_a   (ld_req),
    .req_b   (if_req),
    .hs_a    (ld_ar_hs),
    .hs_b    (if_ar_hs),
    .rd_done (mem_r_done),
    .done    (1'b0)
);

bind load_unit mem_access_checker u_ld_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_a   (ld_req),
    .req_b   (1'b0),
    .hs_a    (ld_ar_hs),
    .hs_b    (1'b0),
    .rd_done (r_done),
    .done    (ld_done)
);

//--- tests/mem_access_tb.sv
`timescale 1ns/1ps

module mem_access_tb import mem_access_pkg::*; ();

    localparam int MEM_DEPTH   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int RST_CYCLES  = 16;

    typedef struct packed {
        logic [7:0] kind;   // W, P, L, F or B
        xlen_t      a;      // address, ex_result or rs1
        xlen_t      b;      // preload data or imm
        mem_size_e  size;
        logic       sgn;
        xlen_t      exp_x;  // expected ld_result or wb_result
        xlen_t      pc;
        inst_t      exp_i;
    } cmd_t;

    logic      clk;
    logic      rst_n;
    logic      ld_start;
    xlen_t     rs1_val;
    xlen_t     imm_val;
    mem_size_e ld_size;
    logic      ld_signed;
    xlen_t     ex_result;
    logic      ld_done;
    xlen_t     ld_result;
    xlen_t     wb_result;
    logic      if_start;
    xlen_t     pc;
    logic      if_valid;
    inst_t     inst;
    logic      wr_en;
    xlen_t     wr_addr;
    xlen_t     wr_data;

    cmd_t      cmds[$];
    int        n_cmds;
    int        n_checks;
    string     test_name;

    mem_access_top #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_start  (ld_start),
        .rs1_val   (rs1_val),
        .imm_val   (imm_val),
        .ld_size   (ld_size),
        .ld_signed (ld_signed),
        .ex_result (ex_result),
        .ld_done   (ld_done),
        .ld_result (ld_result),
        .wb_result (wb_result),
        .if_start  (if_start),
        .pc        (pc),
        .if_valid  (if_valid),
        .inst      (inst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end else begin
            n_checks++;
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end else begin
            n_checks++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_with_failure($sformatf("error %s: expected %0d done pulses, actual %0d",
                                        name, exp, act));
        end else begin
            n_checks++;
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic read_golden();
        int    fd;
        int    n;
        int    want;
        int    sz;
        int    sg;
        string tok;
        xlen_t v1;
        xlen_t v2;
        xlen_t v3;
        xlen_t v4;
        inst_t vi;
        cmd_t  cmd;
        fd = $fopen("tests/mem_access_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open tests/mem_access_golden.txt");
        end
        forever begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) break;
            cmd = '0;
            cmd.kind = tok[0];
            sz = 0;
            sg = 0;
            case (cmd.kind)
                "#": begin
                    skip_line(fd); // column notes
                    n = 0;
                    want = 0;
                end
                "W", "P", "F": begin
                    n = $fscanf(fd, "%h %h", v1, v2);
                    want = 2;
                end
                "L": begin
                    n = $fscanf(fd, "%h %h %d %d %h", v1, v2, sz, sg, v3);
                    want = 5;
                end
                "B": begin
                    n = $fscanf(fd, "%h %h %d %d %h %h %h", v1, v2, sz, sg, v3, v4, vi);
                    want = 7;
                end
                default: begin
                    stop_with_failure($sformatf("unknown golden command %s", tok));
                end
            endcase
            if (n != want) begin
                stop_with_failure($sformatf("golden line for %s has missing fields", tok));
            end else if (want > 0) begin
                cmd.a     = v1;
                cmd.b     = v2;
                cmd.size  = mem_size_e'(sz[1:0]);
                cmd.sgn   = sg[0];
                cmd.exp_x = (cmd.kind == "L" || cmd.kind == "B") ? v3 : v2;
                cmd.pc    = (cmd.kind == "B") ? v4 : v1;
                cmd.exp_i = (cmd.kind == "B") ? vi : v2[31:0];
                cmds.push_back(cmd);
            end
        end
        $fclose(fd);
        n_cmds = cmds.size();
    endtask

    task automatic write_word(input xlen_t addr, input xlen_t data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    task automatic pass_through(input string name, input xlen_t ex, input xlen_t exp);
        @(posedge clk);
        ex_result <= ex;
        @(negedge clk);
        check_xlen(name, exp, wb_result);
    endtask

    task automatic run_load(input string name, input cmd_t c);
        int seen;
        @(posedge clk);
        ld_start  <= 1'b1;
        rs1_val   <= c.a;
        imm_val   <= c.b;
        ld_size   <= c.size;
        ld_signed <= c.sgn;
        @(posedge clk);
        rs1_val   <= ~c.a;        // second start while pending, must be dropped
        imm_val   <= c.b + 64'h8;
        ld_signed <= !c.sgn;
        @(posedge clk);
        ld_start  <= 1'b0;
        do begin
            @(negedge clk);
        end while (!ld_done);
        check_xlen(name, c.exp_x, ld_result);
        check_xlen({name, " wb"}, c.exp_x, wb_result);
        seen = 1;
        repeat (MEM_LATENCY + 4) begin // long enough for a full second load
            @(negedge clk);
            if (ld_done) seen++;
        end
        check_count(name, 1, seen);
    endtask

    task automatic run_fetch(input string name, input xlen_t pcv, input inst_t exp);
        @(posedge clk);
        if_start <= 1'b1;
        pc       <= pcv;
        @(posedge clk);
        if_start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!if_valid);
        check_inst(name, exp, inst);
    endtask

    // load and fetch race for the port, done strobes may come in either order
    task automatic run_both(input string name, input cmd_t c);
        bit got_ld;
        bit got_if;
        @(posedge clk);
        ld_start  <= 1'b1;
        rs1_val   <= c.a;
        imm_val   <= c.b;
        ld_size   <= c.size;
        ld_signed <= c.sgn;
        if_start  <= 1'b1;
        pc        <= c.pc;
        @(posedge clk);
        ld_start  <= 1'b0;
        if_start  <= 1'b0;
        got_ld = 1'b0;
        got_if = 1'b0;
        while (!(got_ld && got_if)) begin
            @(negedge clk);
            if (ld_done) begin
                check_xlen({name, " load"}, c.exp_x, ld_result);
                got_ld = 1'b1;
            end
            if (if_valid) begin
                check_inst({name, " fetch"}, c.exp_i, inst);
                got_if = 1'b1;
            end
        end
    endtask

    initial begin
        wait (n_cmds > 0);
        repeat (RST_CYCLES + 20 + n_cmds * (MEM_LATENCY + 10)) @(posedge clk);
        stop_with_failure("timeout: no done strobe");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        ld_start  = 1'b0;
        rs1_val   = '0;
        imm_val   = '0;
        ld_size   = SIZE_B;
        ld_signed = 1'b0;
        ex_result = '0;
        if_start  = 1'b0;
        pc        = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        n_checks  = 0;
        n_cmds    = 0;
        read_golden();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        foreach (cmds[i]) begin
            test_name = $sformatf("cmd %0d %c", i + 1, cmds[i].kind);
            case (cmds[i].kind)
                "W":     write_word(cmds[i].a, cmds[i].b);
                "P":     pass_through(test_name, cmds[i].a, cmds[i].exp_x);
                "L":     run_load(test_name, cmds[i]);
                "F":     run_fetch(test_name, cmds[i].pc, cmds[i].exp_i);
                default: run_both(test_name, cmds[i]);
            endcase
        end
        repeat (2) @(posedge clk);
        if (n_checks > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure("golden file held no checks");
        end
    end

endmodule

//--- tests/mem_access_golden.txt
# W addr data | P ex_result exp_wb | F pc exp_inst
# L rs1 imm size signed exp_result | B rs1 imm size signed exp_result pc exp_inst (size 0=B 1=H 2=W 3=D)
P 123456789ABCDEF0 123456789ABCDEF0
W 0 0123456789ABCDEF
W 8 FEDCBA9876543210
W 40 00C58533FE010113
W 48 0000806700A13423
W 80 8000000000000001
L 0 0 0 1 FFFFFFFFFFFFFFEF
L 0 0 0 0 00000000000000EF
L 0 1 0 1 FFFFFFFFFFFFFFCD
L 8 2 0 1 0000000000000054
L 10 FFFFFFFFFFFFFFF3 0 1 FFFFFFFFFFFFFF89
L 8 4 0 0 0000000000000098
L 4 1 0 1 0000000000000045
L 8 6 0 1 FFFFFFFFFFFFFFDC
L 0 7 0 0 0000000000000001
L 0 0 1 1 FFFFFFFFFFFFCDEF
L 0 2 1 0 00000000000089AB
L 8 2 1 1 0000000000007654
L 8 4 1 1 FFFFFFFFFFFFBA98
L 0 6 1 0 0000000000000123
L 0 0 2 0 0000000089ABCDEF
L 8 4 2 1 FFFFFFFFFEDCBA98
L 0 4 2 1 0000000001234567
L 80 0 3 1 8000000000000001
L 100 FFFFFFFFFFFFFF08 3 0 FEDCBA9876543210
F 40 FE010113
F 44 00C58533
F 48 00A13423
F 4C 00008067
B 0 C 2 1 FFFFFFFFFEDCBA98 44 00C58533
B 80 0 3 0 8000000000000001 48 00A13423
B 0 3 0 0 0000000000000089 4C 00008067
P FFFFFFFF00000000 FFFFFFFF00000000

//--- project.f
source/mem_access_pkg.sv
source/load_unit.sv
source/fetch_unit.sv
source/read_arbiter.sv
source/data_memory.sv
source/mem_access_top.sv
tests/mem_access_checker.sv
tests/mem_access_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module mem_access_tb \
    -f project.f \
    -o mem_access_sim

./obj_dir/mem_access_sim 2>&1 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
